//--- hdl/prbs_bist_defines.svh
`ifndef PRBS_BIST_DEFINES_SVH
`define PRBS_BIST_DEFINES_SVH

// time-interleaved lanes per adc clock
`define PB_NTI 16

// adc code width, two's complement
`define PB_NADC 8

// prbs history length
`define PB_NPRBS 32

// error and total counter width
`define PB_NCOUNT 64

`endif

//--- hdl/prbs_bist_pkg.sv
`include "prbs_bist_defines.svh"

package prbs_bist_pkg;

    // one signed adc code
    typedef logic signed [`PB_NADC-1:0] adc_code_t;
    // all lane codes, lane k at bits 8k+7:8k
    typedef logic [`PB_NTI*`PB_NADC-1:0] adc_word_t;
    // one bit per lane, bit 0 earliest in serial order
    typedef logic [`PB_NTI-1:0] lane_bits_t;
    // prbs history or tap mask, bit 0 newest
    typedef logic [`PB_NPRBS-1:0] prbs_state_t;
    typedef logic [`PB_NCOUNT-1:0] bit_count_t;

    typedef enum logic [1:0] {
        CHK_IDLE  = 2'd0,
        CHK_ALIGN = 2'd1,
        CHK_TEST  = 2'd2
    } chk_mode_e;

    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } prbs_src_e;

endpackage

//--- hdl/adc_slicer_bank.sv
`timescale 1ns/1ps
`include "prbs_bist_defines.svh"

module adc_slicer_bank (
    input  logic                       clk_adc,
    input  logic                       rst_i,
    input  prbs_bist_pkg::adc_word_t   adc_codes_i,
    input  prbs_bist_pkg::adc_code_t   thresh_i,
    output prbs_bist_pkg::lane_bits_t  bits_o
);
    import prbs_bist_pkg::*;

    // unpacked view of the flattened lane codes
    adc_code_t  lane_code [`PB_NTI];
    lane_bits_t decisions;

    always_comb begin
        for (int k = 0; k < `PB_NTI; k++) begin
            lane_code[k] = adc_code_t'(adc_codes_i[k*`PB_NADC +: `PB_NADC]);
        end
    end

    // signed compare, strictly above threshold slices to 1
    always_comb begin
        for (int k = 0; k < `PB_NTI; k++) begin
            decisions[k] = (lane_code[k] > thresh_i);
        end
    end

    // one cycle from code to decision
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= decisions;
        end
    end

endmodule

//--- hdl/prbs_word_gen.sv
`timescale 1ns/1ps
`include "prbs_bist_defines.svh"

module prbs_word_gen (
    input  logic                         clk_adc,
    input  logic                         rst_i,
    input  logic                         cke_i,
    input  prbs_bist_pkg::prbs_state_t   init_i,
    input  prbs_bist_pkg::prbs_state_t   eqn_i,
    input  logic                         inj_err_i,
    output prbs_bist_pkg::lane_bits_t    bits_o
);
    import prbs_bist_pkg::*;

    // generator history, bit 0 is the newest bit
    prbs_state_t hist;
    prbs_state_t next_hist;
    lane_bits_t  next_word;
    lane_bits_t  inj_mask;

    // unroll 16 serial steps of the lfsr
    always_comb begin
        prbs_state_t walk;
        walk = hist;
        for (int k = 0; k < `PB_NTI; k++) begin
            next_word[k] = ^(walk & eqn_i);
            walk = {walk[`PB_NPRBS-2:0], next_word[k]};
        end
        next_hist = walk;
    end

    // injected error only ever hits lane 0
    assign inj_mask = lane_bits_t'(inj_err_i);

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            hist <= init_i;
        end else if (cke_i) begin
            hist <= next_hist;
        end
    end

    // the flip goes into the output word only, history stays clean
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            bits_o <= '0;
        end else if (cke_i) begin
            bits_o <= next_word ^ inj_mask;
        end
    end

endmodule

//--- hdl/prbs_word_checker.sv
`timescale 1ns/1ps
`include "prbs_bist_defines.svh"

module prbs_word_checker (
    input  logic                         clk_adc,
    input  logic                         rst_i,
    input  prbs_bist_pkg::lane_bits_t    adc_bits_i,
    input  prbs_bist_pkg::lane_bits_t    bist_bits_i,
    input  prbs_bist_pkg::prbs_src_e     sel_src_i,
    input  prbs_bist_pkg::chk_mode_e     mode_i,
    input  prbs_bist_pkg::prbs_state_t   eqn_i,
    input  prbs_bist_pkg::lane_bits_t    chan_sel_i,
    output prbs_bist_pkg::bit_count_t    err_bits_o,
    output prbs_bist_pkg::bit_count_t    total_bits_o,
    output prbs_bist_pkg::lane_bits_t    prbs_flags_o
);
    import prbs_bist_pkg::*;

    function automatic bit_count_t popcount(input lane_bits_t v);
        bit_count_t n;
        n = '0;
        for (int k = 0; k < `PB_NTI; k++) begin
            n = n + bit_count_t'(v[k]);
        end
        return n;
    endfunction

    lane_bits_t  rx_bits;
    lane_bits_t  pred_bits;
    lane_bits_t  err_lanes;
    lane_bits_t  masked_err;
    prbs_state_t hist;
    prbs_state_t next_hist;
    bit_count_t  sel_count;
    bit_count_t  err_count;

    assign rx_bits = (sel_src_i == SRC_BIST) ? bist_bits_i : adc_bits_i;

    // self-synchronizing predictor
    // each lane is predicted from history, then the received bit is shifted in
    always_comb begin
        prbs_state_t walk;
        walk = hist;
        for (int k = 0; k < `PB_NTI; k++) begin
            pred_bits[k] = ^(walk & eqn_i);
            walk = {walk[`PB_NPRBS-2:0], rx_bits[k]};
        end
        next_hist = walk;
    end

    assign err_lanes  = pred_bits ^ rx_bits;
    assign masked_err = err_lanes & chan_sel_i;
    assign sel_count  = popcount(chan_sel_i);
    assign err_count  = popcount(masked_err);

    // history follows the received stream in align and test
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            hist <= '0;
        end else if (mode_i == CHK_ALIGN || mode_i == CHK_TEST) begin
            hist <= next_hist;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            err_bits_o   <= '0;
            total_bits_o <= '0;
            prbs_flags_o <= '0;
        end else begin
            case (mode_i)
                CHK_ALIGN: begin
                    // counters hold while locking
                    prbs_flags_o <= '0;
                end
                CHK_TEST: begin
                    err_bits_o   <= err_bits_o + err_count;
                    total_bits_o <= total_bits_o + sel_count;
                    prbs_flags_o <= masked_err;
                end
                default: begin
                    // idle, and the unused encoding
                    err_bits_o   <= '0;
                    total_bits_o <= '0;
                    prbs_flags_o <= '0;
                end
            endcase
        end
    end

endmodule

//--- hdl/prbs_bist_top.sv
`timescale 1ns/1ps

module prbs_bist_top (
    input  logic                         clk_adc,
    input  logic                         rst_i,
    // adc side
    input  prbs_bist_pkg::adc_word_t     adc_codes_i,
    input  prbs_bist_pkg::adc_code_t     adc_thresh_i,
    input  prbs_bist_pkg::prbs_src_e     sel_prbs_src_i,
    // bist generator controls
    input  logic                         gen_cke_i,
    input  prbs_bist_pkg::prbs_state_t   gen_init_i,
    input  prbs_bist_pkg::prbs_state_t   gen_eqn_i,
    input  logic                         gen_inj_err_i,
    // checker controls
    input  prbs_bist_pkg::chk_mode_e     chk_mode_i,
    input  prbs_bist_pkg::prbs_state_t   chk_eqn_i,
    input  prbs_bist_pkg::lane_bits_t    chk_chan_sel_i,
    output prbs_bist_pkg::bit_count_t    err_bits_o,
    output prbs_bist_pkg::bit_count_t    total_bits_o,
    output prbs_bist_pkg::lane_bits_t    prbs_flags_o
);
    import prbs_bist_pkg::*;

    // sliced adc decisions, one cycle behind the codes
    lane_bits_t adc_bits;
    // parallel bist word
    lane_bits_t bist_bits;

    adc_slicer_bank slicer_i (
        .clk_adc     (clk_adc),
        .rst_i       (rst_i),
        .adc_codes_i (adc_codes_i),
        .thresh_i    (adc_thresh_i),
        .bits_o      (adc_bits)
    );

    prbs_word_gen gen_i (
        .clk_adc   (clk_adc),
        .rst_i     (rst_i),
        .cke_i     (gen_cke_i),
        .init_i    (gen_init_i),
        .eqn_i     (gen_eqn_i),
        .inj_err_i (gen_inj_err_i),
        .bits_o    (bist_bits)
    );

    prbs_word_checker chk_i (
        .clk_adc      (clk_adc),
        .rst_i        (rst_i),
        .adc_bits_i   (adc_bits),
        .bist_bits_i  (bist_bits),
        .sel_src_i    (sel_prbs_src_i),
        .mode_i       (chk_mode_i),
        .eqn_i        (chk_eqn_i),
        .chan_sel_i   (chk_chan_sel_i),
        .err_bits_o   (err_bits_o),
        .total_bits_o (total_bits_o),
        .prbs_flags_o (prbs_flags_o)
    );

endmodule

//--- dv/prbs_bist_chk.sv
`timescale 1ns/1ps

module prbs_bist_chk (
    input logic                        clk_adc,
    input logic                        rst_i,
    input prbs_bist_pkg::chk_mode_e    mode_i,
    input prbs_bist_pkg::bit_count_t   err_bits_i,
    input prbs_bist_pkg::bit_count_t   total_bits_i,
    input prbs_bist_pkg::lane_bits_t   flags_i
);
    import prbs_bist_pkg::*;

    // number of failed properties so far
    int fail_count = 0;

    // flags only carry errors while testing
    flags_quiet_a: assert property (@(posedge clk_adc) disable iff (rst_i)
        (mode_i != CHK_TEST) |=> (flags_i == '0))
        else begin
            fail_count++;
            $error("prbs flags set outside test mode");
        end

    err_le_total_a: assert property (@(posedge clk_adc) total_bits_i >= err_bits_i)
        else begin
            fail_count++;
            $error("error count above total count");
        end

    total_monotonic_a: assert property (@(posedge clk_adc) disable iff (rst_i)
        (mode_i == CHK_TEST) |=> (total_bits_i >= $past(total_bits_i)))
        else begin
            fail_count++;
            $error("total count went down during test");
        end

    // everything cleared one cycle after reset
    reset_clear_a: assert property (@(posedge clk_adc)
        rst_i |=> (err_bits_i == '0 && total_bits_i == '0 && flags_i == '0))
        else begin
            fail_count++;
            $error("checker outputs not zero after reset");
        end

endmodule

bind prbs_word_checker prbs_bist_chk chk_props (
    .clk_adc      (clk_adc),
    .rst_i        (rst_i),
    .mode_i       (mode_i),
    .err_bits_i   (err_bits_o),
    .total_bits_i (total_bits_o),
    .flags_i      (prbs_flags_o)
);

//--- dv/prbs_bist_tb.sv
`timescale 1ns/1ps
`include "prbs_bist_defines.svh"

module prbs_bist_tb;
    import prbs_bist_pkg::*;

    localparam int NROWS = 12;
    // x^7+x^6+1, x^15+x^14+1, x^31+x^28+1 with bit i at delay i+1
    localparam prbs_state_t PRBS7  = 32'h0000_0060;
    localparam prbs_state_t PRBS15 = 32'h0000_6000;
    localparam prbs_state_t PRBS31 = 32'h4800_0000;

    // inj_at and hold_at count test cycles where -1 means none
    // exp_err of -1 leaves the error count to the model
    typedef struct packed {
        prbs_src_e   src;
        prbs_state_t gen_eqn;
        prbs_state_t chk_eqn;
        prbs_state_t gen_init;
        lane_bits_t  chan_sel;
        adc_code_t   thresh;
        int          n_align;
        int          n_test;
        int          inj_at;
        int          hold_at;
        int          exp_err;
    } row_t;

    logic        clk_adc;
    logic        rst_i;
    adc_word_t   adc_codes_i;
    adc_code_t   adc_thresh_i;
    prbs_src_e   sel_prbs_src_i;
    logic        gen_cke_i;
    prbs_state_t gen_init_i;
    prbs_state_t gen_eqn_i;
    logic        gen_inj_err_i;
    chk_mode_e   chk_mode_i;
    prbs_state_t chk_eqn_i;
    lane_bits_t  chk_chan_sel_i;
    bit_count_t  err_bits_o;
    bit_count_t  total_bits_o;
    lane_bits_t  prbs_flags_o;

    row_t   rows [NROWS];
    string  names [NROWS];
    integer seed;
    int     errors;
    int     row_errors;
    int     failed_rows;
    longint timeout_ns = 0;

    // reference model state, updated once per clock edge
    prbs_state_t m_gen_hist;
    lane_bits_t  m_gen_word;
    lane_bits_t  m_slice;
    prbs_state_t m_chk_hist;
    bit_count_t  m_err;
    bit_count_t  m_total;
    lane_bits_t  m_flags;

    prbs_bist_top uut (
        .clk_adc        (clk_adc),
        .rst_i          (rst_i),
        .adc_codes_i    (adc_codes_i),
        .adc_thresh_i   (adc_thresh_i),
        .sel_prbs_src_i (sel_prbs_src_i),
        .gen_cke_i      (gen_cke_i),
        .gen_init_i     (gen_init_i),
        .gen_eqn_i      (gen_eqn_i),
        .gen_inj_err_i  (gen_inj_err_i),
        .chk_mode_i     (chk_mode_i),
        .chk_eqn_i      (chk_eqn_i),
        .chk_chan_sel_i (chk_chan_sel_i),
        .err_bits_o     (err_bits_o),
        .total_bits_o   (total_bits_o),
        .prbs_flags_o   (prbs_flags_o)
    );

    always #4 clk_adc = ~clk_adc;

    // parity of the tapped history bits
    function automatic logic next_bit(input prbs_state_t hist, input prbs_state_t taps);
        logic p;
        p = 1'b0;
        for (int i = 0; i < `PB_NPRBS; i++) begin
            if (taps[i]) begin
                p = p ^ hist[i];
            end
        end
        return p;
    endfunction

    function automatic int ones(input lane_bits_t v);
        int n;
        n = 0;
        for (int k = 0; k < `PB_NTI; k++) begin
            if (v[k]) begin
                n++;
            end
        end
        return n;
    endfunction

    // what the dut registers on the coming edge, from the inputs now driven
    task automatic model_step();
        lane_bits_t rx;
        lane_bits_t miss;
        lane_bits_t word;
        adc_code_t  code;
        rx = (sel_prbs_src_i == SRC_BIST) ? m_gen_word : m_slice;
        miss = '0;
        word = m_gen_word;
        if (rst_i) begin
            m_gen_hist = gen_init_i;
            m_gen_word = '0;
            m_slice    = '0;
            m_chk_hist = '0;
            m_err      = '0;
            m_total    = '0;
            m_flags    = '0;
        end else begin
            if (chk_mode_i == CHK_ALIGN || chk_mode_i == CHK_TEST) begin
                for (int k = 0; k < `PB_NTI; k++) begin
                    miss[k] = next_bit(m_chk_hist, chk_eqn_i) ^ rx[k];
                    m_chk_hist = {m_chk_hist[`PB_NPRBS-2:0], rx[k]};
                end
            end
            if (chk_mode_i == CHK_TEST) begin
                m_err   = m_err + bit_count_t'(ones(miss & chk_chan_sel_i));
                m_total = m_total + bit_count_t'(ones(chk_chan_sel_i));
                m_flags = miss & chk_chan_sel_i;
            end else begin
                m_flags = '0;
                if (chk_mode_i == CHK_IDLE) begin
                    m_err   = '0;
                    m_total = '0;
                end
            end
            // signed code strictly above the threshold
            for (int k = 0; k < `PB_NTI; k++) begin
                code = adc_codes_i[k*`PB_NADC +: `PB_NADC];
                m_slice[k] = (int'(code) > int'(adc_thresh_i));
            end
            if (gen_cke_i) begin
                for (int k = 0; k < `PB_NTI; k++) begin
                    word[k] = next_bit(m_gen_hist, gen_eqn_i);
                    m_gen_hist = {m_gen_hist[`PB_NPRBS-2:0], word[k]};
                end
                word[0] = word[0] ^ gen_inj_err_i;
                m_gen_word = word;
            end
        end
    endtask

    task automatic advance_cycle();
        adc_codes_i = {$random(seed), $random(seed), $random(seed), $random(seed)};
        model_step();
        @(posedge clk_adc);
        #1;
        compare_count("prbs_flags_o", bit_count_t'(prbs_flags_o), bit_count_t'(m_flags));
    endtask

    task automatic compare_count(input string sig, input bit_count_t got,
                                 input bit_count_t want);
        assert (got == want) else begin
            $display("MISMATCH time=%0t %s expected=%0d actual=%0d", $time, sig, want, got);
            row_errors++;
        end
    endtask

    task automatic fill_table();
        rows[0]  = '{SRC_BIST, PRBS7, PRBS7, 32'h0000_007F, 16'hFFFF, 8'sd0, 4, 8, -1, -1, 0};
        names[0] = "clean loopback prbs7";
        rows[1]  = '{SRC_BIST, PRBS31, PRBS31, 32'h2468_ACE1, 16'hFFFF, 8'sd0, 4, 10, -1, -1, 0};
        names[1] = "clean loopback prbs31";
        // one flip plus one per tap
        rows[2]  = '{SRC_BIST, PRBS7, PRBS7, 32'h0000_007F, 16'hFFFF, 8'sd0, 4, 8, 4, -1, 3};
        names[2] = "injection prbs7";
        rows[3]  = '{SRC_BIST, PRBS31, PRBS31, 32'h2468_ACE1, 16'hFFFF, 8'sd0, 4, 8, 4, -1, 3};
        names[3] = "injection prbs31";
        // only the echoes on lanes 6 and 7 count while lane 0 is masked
        rows[4]  = '{SRC_BIST, PRBS7, PRBS7, 32'h0000_007F, 16'hFFFE, 8'sd0, 4, 8, 4, -1, 2};
        names[4] = "injection lane 0 masked";
        rows[5]  = '{SRC_BIST, PRBS7, PRBS7, 32'h0000_0055, 16'h00C1, 8'sd0, 4, 8, 2, -1, 3};
        names[5] = "lane mask 0,6,7";
        rows[6]  = '{SRC_BIST, PRBS31, PRBS31, 32'h2468_ACE1, 16'h0F0F, 8'sd0, 4, 8, 3, -1, -1};
        names[6] = "lane mask 0f0f";
        rows[7]  = '{SRC_BIST, PRBS7, PRBS15, 32'h0000_007F, 16'hFFFF, 8'sd0, 4, 8, -1, -1, -1};
        names[7] = "tap mismatch";
        rows[8]  = '{SRC_ADC, PRBS7, PRBS7, 32'h0000_007F, 16'hFFFF, 8'sd0, 4, 8, -1, -1, -1};
        names[8] = "adc threshold 0";
        rows[9]  = '{SRC_ADC, PRBS7, PRBS7, 32'h0000_007F, 16'hFFFF, -8'sd40, 4, 8, -1, -1, -1};
        names[9] = "adc threshold -40";
        rows[10] = '{SRC_ADC, PRBS7, PRBS31, 32'h0000_007F, 16'h3CF0, 8'sd25, 4, 8, -1, -1, -1};
        names[10] = "adc threshold 25";
        rows[11] = '{SRC_BIST, PRBS7, PRBS7, 32'h0000_007F, 16'hFFFF, 8'sd0, 4, 8, -1, 3, -1};
        names[11] = "generator clock enable low";
    endtask

    task automatic run_row(input int r);
        row_t       row;
        bit_count_t want_total;
        bit_count_t got_err;
        bit_count_t got_total;
        row = rows[r];
        row_errors = 0;
        sel_prbs_src_i = row.src;
        gen_eqn_i      = row.gen_eqn;
        gen_init_i     = row.gen_init;
        chk_eqn_i      = row.chk_eqn;
        chk_chan_sel_i = row.chan_sel;
        adc_thresh_i   = row.thresh;
        gen_cke_i      = 1'b1;
        gen_inj_err_i  = 1'b0;
        chk_mode_i     = CHK_IDLE;
        rst_i          = 1'b1;
        repeat (3) advance_cycle();
        rst_i = 1'b0;
        for (int c = 0; c < row.n_align + row.n_test; c++) begin
            if (c < row.n_align) begin
                chk_mode_i = CHK_ALIGN;
            end else begin
                chk_mode_i = CHK_TEST;
            end
            gen_inj_err_i = (row.inj_at >= 0 && c == row.n_align + row.inj_at);
            gen_cke_i     = !(row.hold_at >= 0 && c == row.n_align + row.hold_at);
            advance_cycle();
        end
        want_total = bit_count_t'(ones(row.chan_sel) * row.n_test);
        if (row.exp_err >= 0) begin
            compare_count("err_bits_o", err_bits_o, bit_count_t'(row.exp_err));
        end
        compare_count("err_bits_o", err_bits_o, m_err);
        compare_count("total_bits_o", total_bits_o, want_total);
        if (row.src == SRC_BIST && row.gen_eqn != row.chk_eqn) begin
            assert (err_bits_o != '0) else begin
                $display("row %0d: taps differ but no errors were counted", r);
                row_errors++;
            end
        end
        got_err   = err_bits_o;
        got_total = total_bits_o;
        // idle clears both counters
        chk_mode_i    = CHK_IDLE;
        gen_inj_err_i = 1'b0;
        gen_cke_i     = 1'b1;
        advance_cycle();
        compare_count("err_bits_o", err_bits_o, '0);
        compare_count("total_bits_o", total_bits_o, '0);
        $display("row %0d %s: err %0d total %0d, %s", r, names[r], got_err,
                 got_total, (row_errors == 0) ? "ok" : "FAILED");
        errors = errors + row_errors;
        if (row_errors != 0) begin
            failed_rows++;
        end
    endtask

    initial begin
        int cyc;
        int assert_fails;
        clk_adc        = 1'b0;
        rst_i          = 1'b1;
        adc_codes_i    = '0;
        adc_thresh_i   = '0;
        sel_prbs_src_i = SRC_BIST;
        gen_cke_i      = 1'b0;
        gen_init_i     = '0;
        gen_eqn_i      = '0;
        gen_inj_err_i  = 1'b0;
        chk_mode_i     = CHK_IDLE;
        chk_eqn_i      = '0;
        chk_chan_sel_i = '0;
        seed           = 46;
        errors         = 0;
        failed_rows    = 0;
        fill_table();
        // reset, align, test and idle cycles of every row
        cyc = 1;
        for (int r = 0; r < NROWS; r++) begin
            cyc = cyc + 3 + rows[r].n_align + rows[r].n_test + 1;
        end
        timeout_ns = longint'(2 * cyc * 8);
        @(posedge clk_adc);
        #1;
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        assert_fails = uut.chk_i.chk_props.fail_count;
        $display("rows %0d, failed rows %0d, failed checks %0d, property failures %0d",
                 NROWS, failed_rows, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (timeout_ns != 0);
        #(timeout_ns);
        $display("watchdog: tests did not finish within %0d ns", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- prbs_bist.f
+incdir+hdl
hdl/prbs_bist_pkg.sv
hdl/adc_slicer_bank.sv
hdl/prbs_word_gen.sv
hdl/prbs_word_checker.sv
hdl/prbs_bist_top.sv
dv/prbs_bist_chk.sv
dv/prbs_bist_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the prbs bist testbench with verilator
set -u

root_dir="$(cd "$(dirname "${BASH_SOURCE[0]}")" && pwd)"
cd "$root_dir" || exit 1

top=prbs_bist_tb
build_dir=obj_dir
log_file=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "error: verilator not found in PATH"
    exit 1
fi

rm -rf "$build_dir" "$log_file"

verilator --binary --timing --assert -j 0 \
    --top-module "$top" \
    -Mdir "$build_dir" \
    -f prbs_bist.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "error: verilator build failed with status $build_status"
    exit 1
fi

# keep running past a failed property so the testbench can report it
"./$build_dir/V$top" +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
    echo "error: simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$log_file"; then
    echo "result: PASS"
    exit 0
fi

echo "result: FAIL"
exit 1
